//--- src.f
+incdir+include
design/ssram_pkg.sv
design/dp_sram.sv
design/axi_read_engine.sv
design/axi_write_engine.sv
design/ssram_axi_top.sv
dv/tb_ssram_axi.sv

//--- run.sh
#!/usr/bin/env bash
# Builds the SSRAM AXI testbench with Verilator and runs it.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --timescale 1ns/1ps --top-module tb_ssram_axi \
  -f src.f -Mdir obj_dir -o sim_tb
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/sim_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "Some tests failed" "$LOG"; then
  exit 1
fi
if ! grep -q "All tests passed" "$LOG"; then
  echo "Simulation ended without a result line"
  exit 1
fi
exit 0

//--- dv/tb_ssram_axi.sv
/* SSRAM AXI testbench */

`timescale 1ns/1ps
`include "ssram_params.svh"

module tb_ssram_axi;

  localparam int TIMEOUT = 200; // Cycles per wait.

  logic               clk;
  logic               rst_n;
  ssram_pkg::axi_ax_t aw;
  logic               aw_valid;
  logic               aw_ready;
  ssram_pkg::axi_w_t  w;
  logic               w_valid;
  logic               w_ready;
  ssram_pkg::axi_b_t  b;
  logic               b_valid;
  logic               b_ready;
  ssram_pkg::axi_ax_t ar;
  logic               ar_valid;
  logic               ar_ready;
  ssram_pkg::axi_r_t  r;
  logic               r_valid;
  logic               r_ready;

  int          seed = 93;
  int          errors;
  int          checks;
  logic [31:0] rnd;
  logic [63:0] ref_mem [logic [31:0]]; // Keyed by word index.
  logic [63:0] beat_data [$];
  logic [7:0]  beat_strb [$];

  ssram_axi_top i_ssram_axi_top (.*);

  initial clk = 1'b0;
  always #4 clk = ~clk;

  ////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////
  function automatic logic in_range(input logic [31:0] a);
    return a < (32'd8 << `SSRAM_DEPTH_LOG2);
  endfunction

  function automatic logic [31:0] next_addr(input logic [31:0] a, input logic [7:0] len,
                                            input ssram_pkg::axi_burst_t burst);
    logic [31:0] win;
    logic [31:0] base;
    win  = ({24'b0, len} + 32'd1) << 3; // Wrap window in bytes.
    base = a - (a % win);
    case (burst)
      ssram_pkg::FIXED: return a;
      ssram_pkg::WRAP:  return base + ((a - base + 32'd8) % win);
      default:          return a + 32'd8;
    endcase
  endfunction

  function automatic void ref_write(input logic [31:0] a, input logic [63:0] data,
                                    input logic [7:0] strb);
    logic [63:0] word;
    if (!in_range(a)) return;
    word = ref_mem.exists(a >> 3) ? ref_mem[a >> 3] : '0;
    for (int i = 0; i < 8; i++) begin
      if (strb[i]) word[8*i +: 8] = data[8*i +: 8];
    end
    ref_mem[a >> 3] = word;
  endfunction

  function automatic ssram_pkg::axi_r_t ref_read(input logic [31:0] a,
                                                 input logic [`SSRAM_ID_WIDTH-1:0] id,
                                                 input logic last);
    ssram_pkg::axi_r_t exp;
    exp.id   = id;
    exp.last = last;
    exp.data = '0;
    exp.resp = ssram_pkg::DECERR;
    if (in_range(a)) begin
      exp.resp = ssram_pkg::OKAY;
      if (ref_mem.exists(a >> 3)) exp.data = ref_mem[a >> 3];
    end
    return exp;
  endfunction

  ////////////////////////////////////////
  // Checks
  ////////////////////////////////////////
  task automatic check_flag(input string name, input logic exp, input logic got);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("mismatch %s: expected %b, actual %b", name, exp, got);
    end
  endtask

  task automatic check_b(input string name, input ssram_pkg::axi_b_t exp,
                         input ssram_pkg::axi_b_t got);
    checks++;
    if (got.id !== exp.id || got.resp !== exp.resp) begin
      errors++;
      $display("mismatch %s: B expected id %h resp %0d, actual id %h resp %0d",
               name, exp.id, exp.resp, got.id, got.resp);
    end
  endtask

  // Fields shown as id/data/resp/last.
  task automatic check_r(input string name, input ssram_pkg::axi_r_t exp,
                         input ssram_pkg::axi_r_t got);
    checks++;
    if (got.id !== exp.id || got.data !== exp.data || got.resp !== exp.resp ||
        got.last !== exp.last) begin
      errors++;
      $display("mismatch %s: R expected %h/%h/%0d/%b, actual %h/%h/%0d/%b", name,
               exp.id, exp.data, exp.resp, exp.last, got.id, got.data, got.resp, got.last);
    end
  endtask

  task automatic stop_on_timeout(input string what);
    errors++;
    $display("Timeout: %s did not complete within %0d cycles", what, TIMEOUT);
    $display("Checks: %0d, errors: %0d", checks, errors);
    $display("Some tests failed");
    $finish;
  endtask

  ////////////////////////////////////////
  // AXI master
  ////////////////////////////////////////
  function automatic logic coin_flip();
    int v;
    v = $random(seed);
    return v[0];
  endfunction

  task automatic load_beats(input int n, input logic rand_strb);
    beat_data.delete();
    beat_strb.delete();
    repeat (n) begin
      beat_data.push_back({$random(seed), $random(seed)});
      rnd = $random(seed);
      beat_strb.push_back(rand_strb ? rnd[7:0] : 8'hFF);
    end
  endtask

  task automatic write_burst(input string name, input logic [`SSRAM_ID_WIDTH-1:0] id,
                             input logic [31:0] addr, input logic [7:0] len,
                             input ssram_pkg::axi_burst_t burst, input logic stall);
    ssram_pkg::axi_b_t exp;
    logic [31:0]       a;
    int                t;
    a        = addr;
    exp.id   = id;
    exp.resp = ssram_pkg::OKAY;
    aw.id    = id;
    aw.addr  = addr;
    aw.len   = len;
    aw.burst = burst;
    aw_valid = 1'b1;
    t = 0;
    @(negedge clk);
    while (!aw_ready) begin
      t++;
      if (t > TIMEOUT) stop_on_timeout("write address channel");
      @(negedge clk);
    end
    @(posedge clk);
    #1;
    aw_valid = 1'b0;
    for (int i = 0; i <= int'(len); i++) begin
      w.data  = beat_data[i];
      w.strb  = beat_strb[i];
      w.last  = (i == int'(len));
      w_valid = 1'b1;
      t = 0;
      @(negedge clk);
      while (!w_ready) begin
        t++;
        if (t > TIMEOUT) stop_on_timeout("write data channel");
        @(negedge clk);
      end
      @(posedge clk);
      #1;
      if (!in_range(a)) exp.resp = ssram_pkg::DECERR;
      ref_write(a, beat_data[i], beat_strb[i]);
      a = next_addr(a, len, burst);
    end
    w_valid = 1'b0;
    t = 0;
    b_ready = stall ? coin_flip() : 1'b1;
    @(negedge clk);
    while (!(b_valid && b_ready)) begin
      t++;
      if (t > TIMEOUT) stop_on_timeout("write response channel");
      @(posedge clk);
      #1;
      b_ready = stall ? coin_flip() : 1'b1;
      @(negedge clk);
    end
    check_b(name, exp, b);
    @(posedge clk);
    #1;
    b_ready = 1'b0;
  endtask

  task automatic read_burst(input string name, input logic [`SSRAM_ID_WIDTH-1:0] id,
                            input logic [31:0] addr, input logic [7:0] len,
                            input ssram_pkg::axi_burst_t burst, input logic stall);
    logic [31:0] a;
    int          t;
    int          beat;
    a        = addr;
    ar.id    = id;
    ar.addr  = addr;
    ar.len   = len;
    ar.burst = burst;
    ar_valid = 1'b1;
    t = 0;
    @(negedge clk);
    while (!ar_ready) begin
      t++;
      if (t > TIMEOUT) stop_on_timeout("read address channel");
      @(negedge clk);
    end
    @(posedge clk);
    #1;
    ar_valid = 1'b0;
    beat = 0;
    t = 0;
    while (beat <= int'(len)) begin
      r_ready = stall ? coin_flip() : 1'b1;
      @(negedge clk);
      if (r_valid && r_ready) begin
        check_r(name, ref_read(a, id, beat == int'(len)), r);
        a = next_addr(a, len, burst);
        beat++;
        t = 0;
      end else begin
        t++;
        if (t > TIMEOUT) stop_on_timeout("read data channel");
      end
      @(posedge clk);
      #1;
    end
    r_ready = 1'b0;
    checks++;
    if (r_valid || !ar_ready) begin
      errors++;
      $display("Read burst %s did not return to idle after its last beat", name);
    end
  endtask

  ////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////
  initial begin
    ssram_pkg::axi_burst_t burst;
    logic [31:0]           addr;
    logic [7:0]            len;
    aw       = '0;
    aw_valid = 1'b0;
    w        = '0;
    w_valid  = 1'b0;
    b_ready  = 1'b0;
    ar       = '0;
    ar_valid = 1'b0;
    r_ready  = 1'b0;
    errors   = 0;
    checks   = 0;
    rst_n    = 1'b0;
    repeat (16) @(posedge clk);
    #1;
    rst_n = 1'b1;

    @(negedge clk);
    check_flag("reset aw_ready", 1'b1, aw_ready);
    check_flag("reset ar_ready", 1'b1, ar_ready);
    check_flag("reset w_ready", 1'b0, w_ready);
    check_flag("reset b_valid", 1'b0, b_valid);
    check_flag("reset r_valid", 1'b0, r_valid);
    @(posedge clk);
    #1;

    // Whole SRAM gets a pattern of its own byte address.
    for (int blk = 0; blk < (2 ** `SSRAM_DEPTH_LOG2) / 256; blk++) begin
      beat_data.delete();
      beat_strb.delete();
      for (int i = 0; i < 256; i++) begin
        addr = 32'(blk * 2048 + i * 8);
        beat_data.push_back({~addr, addr});
        beat_strb.push_back(8'hFF);
      end
      write_burst("fill", 4'h0, 32'(blk * 2048), 8'hFF, ssram_pkg::INCR, 1'b0);
    end

    load_beats(8, 1'b0);
    write_burst("incr8", 4'h3, 32'h100, 8'd7, ssram_pkg::INCR, 1'b0);
    read_burst("incr8", 4'h5, 32'h100, 8'd7, ssram_pkg::INCR, 1'b0);

    load_beats(4, 1'b0);
    write_burst("strb_base", 4'h1, 32'h400, 8'd3, ssram_pkg::INCR, 1'b0);
    load_beats(4, 1'b1);
    write_burst("strb_merge", 4'h2, 32'h400, 8'd3, ssram_pkg::INCR, 1'b0);
    read_burst("strb_merge", 4'h2, 32'h400, 8'd3, ssram_pkg::INCR, 1'b0);

    load_beats(4, 1'b0);
    write_burst("wrap4", 4'h7, 32'h210, 8'd3, ssram_pkg::WRAP, 1'b0);
    read_burst("wrap4", 4'h8, 32'h210, 8'd3, ssram_pkg::WRAP, 1'b0);
    read_burst("wrap4_linear", 4'h8, 32'h200, 8'd3, ssram_pkg::INCR, 1'b0);

    load_beats(4, 1'b1);
    write_burst("fixed4", 4'h9, 32'h300, 8'd3, ssram_pkg::FIXED, 1'b0);
    read_burst("fixed4", 4'hA, 32'h300, 8'd3, ssram_pkg::FIXED, 1'b0);

    load_beats(4, 1'b0);
    write_burst("decerr_wr", 4'hB, 32'h2000, 8'd3, ssram_pkg::INCR, 1'b0);
    write_burst("decerr_high", 4'hB, 32'h8000_0000, 8'd3, ssram_pkg::INCR, 1'b0);
    read_burst("decerr_alias", 4'hC, 32'h0, 8'd3, ssram_pkg::INCR, 1'b0);
    read_burst("decerr_rd", 4'hD, 32'h2000, 8'd3, ssram_pkg::INCR, 1'b0);
    write_burst("decerr_edge", 4'hE, 32'h1FF0, 8'd3, ssram_pkg::INCR, 1'b0);
    read_burst("decerr_edge", 4'hE, 32'h1FF0, 8'd3, ssram_pkg::INCR, 1'b0);

    for (int n = 0; n < 20; n++) begin
      rnd  = $random(seed);
      addr = {19'b0, rnd[12:3], 3'b0};
      case (rnd[14:13])
        2'd0: begin
          burst = ssram_pkg::FIXED;
          len   = {4'h0, rnd[18:15]};
        end
        2'd1: begin
          burst = ssram_pkg::WRAP;
          len   = {4'h0, 4'hF >> rnd[16:15]}; // 2, 4, 8 or 16 beats.
        end
        default: begin
          burst = ssram_pkg::INCR;
          len   = {4'h0, rnd[18:15]};
        end
      endcase
      load_beats(int'(len) + 1, 1'b1);
      write_burst("random", rnd[22:19], addr, len, burst, 1'b1);
      read_burst("random", rnd[26:23], addr, len, burst, 1'b1);
    end

    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

//--- design/ssram_axi_top.sv
/* AXI4 SSRAM slave */

`timescale 1ns/1ps
`include "ssram_params.svh"

module ssram_axi_top (
  input  logic               clk,
  input  logic               rst_n,
  input  ssram_pkg::axi_ax_t aw,
  input  logic               aw_valid,
  output logic               aw_ready,
  input  ssram_pkg::axi_w_t  w,
  input  logic               w_valid,
  output logic               w_ready,
  output ssram_pkg::axi_b_t  b,
  output logic               b_valid,
  input  logic               b_ready,
  input  ssram_pkg::axi_ax_t ar,
  input  logic               ar_valid,
  output logic               ar_ready,
  output ssram_pkg::axi_r_t  r,
  output logic               r_valid,
  input  logic               r_ready
);

  logic                         a_en;
  logic [`SSRAM_DEPTH_LOG2-1:0] a_addr;
  logic [`SSRAM_DATA_WIDTH-1:0] a_rdata;
  logic                         b_en;
  logic [`SSRAM_STRB_WIDTH-1:0] b_we;
  logic [`SSRAM_DEPTH_LOG2-1:0] b_addr;
  logic [`SSRAM_DATA_WIDTH-1:0] b_wdata;

  axi_read_engine i_axi_read_engine (
    .clk      (clk),
    .rst_n    (rst_n),
    .ar       (ar),
    .ar_valid (ar_valid),
    .ar_ready (ar_ready),
    .r        (r),
    .r_valid  (r_valid),
    .r_ready  (r_ready),
    .a_en     (a_en),
    .a_addr   (a_addr),
    .a_rdata  (a_rdata)
  );

  axi_write_engine i_axi_write_engine (
    .clk      (clk),
    .rst_n    (rst_n),
    .aw       (aw),
    .aw_valid (aw_valid),
    .aw_ready (aw_ready),
    .w        (w),
    .w_valid  (w_valid),
    .w_ready  (w_ready),
    .b        (b),
    .b_valid  (b_valid),
    .b_ready  (b_ready),
    .b_en     (b_en),
    .b_we     (b_we),
    .b_addr   (b_addr),
    .b_wdata  (b_wdata)
  );

  dp_sram i_dp_sram (
    .clk     (clk),
    .a_en    (a_en),
    .a_addr  (a_addr),
    .a_rdata (a_rdata),
    .b_en    (b_en),
    .b_we    (b_we),
    .b_addr  (b_addr),
    .b_wdata (b_wdata)
  );

endmodule

//--- design/axi_write_engine.sv
/* AXI4 write engine */

`timescale 1ns/1ps
`include "ssram_params.svh"

module axi_write_engine (
  input  logic                           clk,
  input  logic                           rst_n,
  input  ssram_pkg::axi_ax_t             aw,
  input  logic                           aw_valid,
  output logic                           aw_ready,
  input  ssram_pkg::axi_w_t              w,
  input  logic                           w_valid,
  output logic                           w_ready,
  output ssram_pkg::axi_b_t              b,
  output logic                           b_valid,
  input  logic                           b_ready,
  output logic                           b_en,
  output logic [`SSRAM_STRB_WIDTH-1:0]   b_we,
  output logic [`SSRAM_DEPTH_LOG2-1:0]   b_addr,
  output logic [`SSRAM_DATA_WIDTH-1:0]   b_wdata
);

  typedef enum logic [1:0] {
    IDLE,
    PREBURST,
    BURST,
    RESP
  } state_t;

  state_t                     state;
  logic [31:0]                addr;
  logic [7:0]                 len_q;
  ssram_pkg::axi_burst_t      burst_q;
  logic [`SSRAM_ID_WIDTH-1:0] id_q;
  logic [7:0]                 count;
  logic                       err;
  logic                       in_range;
  logic                       aw_hs;
  logic                       w_hs;

  assign in_range = (addr[31:`SSRAM_DEPTH_LOG2+3] == '0);
  assign aw_ready = (state == IDLE);
  assign w_ready  = (state == PREBURST) || (state == BURST);
  assign b_valid  = (state == RESP);
  assign aw_hs    = aw_valid && aw_ready;
  assign w_hs     = w_valid && w_ready;

  assign b.id   = id_q;
  assign b.resp = err ? ssram_pkg::DECERR : ssram_pkg::OKAY;

  // Beats go straight to port B.
  assign b_en    = w_hs && in_range;
  assign b_we    = w.strb;
  assign b_addr  = addr[`SSRAM_DEPTH_LOG2+2:3];
  assign b_wdata = w.data;

  ////////////////////////////////////////
  // Control FSM
  ////////////////////////////////////////
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= IDLE;
      count <= '0;
      err   <= 1'b0;
    end else begin
      case (state)
        IDLE: begin
          if (aw_hs) begin
            count <= aw.len;
            state <= PREBURST;
          end
        end
        PREBURST, BURST: begin
          if (w_valid) begin
            // First beat starts the sticky error afresh.
            err <= !in_range || ((state == BURST) && err);
            if (count == '0) begin
              state <= RESP; // Beat count ends the burst.
            end else begin
              count <= count - 8'd1;
              state <= BURST;
            end
          end
        end
        RESP: begin
          if (b_ready) state <= IDLE;
        end
        default: state <= IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (aw_hs) begin
      addr    <= aw.addr;
      len_q   <= aw.len;
      burst_q <= aw.burst;
      id_q    <= aw.id;
    end else if (w_hs) begin
      addr <= ssram_pkg::next_beat_addr(addr, len_q, burst_q);
    end
  end

endmodule

//--- design/axi_read_engine.sv
/* AXI4 read engine */

`timescale 1ns/1ps
`include "ssram_params.svh"

module axi_read_engine (
  input  logic                           clk,
  input  logic                           rst_n,
  input  ssram_pkg::axi_ax_t             ar,
  input  logic                           ar_valid,
  output logic                           ar_ready,
  output ssram_pkg::axi_r_t              r,
  output logic                           r_valid,
  input  logic                           r_ready,
  output logic                           a_en,
  output logic [`SSRAM_DEPTH_LOG2-1:0]   a_addr,
  input  logic [`SSRAM_DATA_WIDTH-1:0]   a_rdata
);

  typedef enum logic [1:0] {
    IDLE,
    PREBURST,
    BURST
  } state_t;

  state_t                state;
  logic [31:0]           addr;
  logic [7:0]            len_q;
  ssram_pkg::axi_burst_t burst_q;
  logic [7:0]            count;
  logic                  in_range;
  logic                  ar_hs;
  logic                  r_hs;
  logic                  capture;

  assign in_range = (addr[31:`SSRAM_DEPTH_LOG2+3] == '0);
  assign ar_ready = (state == IDLE);
  assign ar_hs    = ar_valid && ar_ready;
  assign r_hs     = r_valid && r_ready;
  assign capture  = (state == BURST) && !r_valid; // SRAM word is on a_rdata.
  assign a_en     = (state == PREBURST) && in_range;
  assign a_addr   = addr[`SSRAM_DEPTH_LOG2+2:3];

  ////////////////////////////////////////
  // Control FSM
  ////////////////////////////////////////
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state   <= IDLE;
      r_valid <= 1'b0;
      count   <= '0;
    end else begin
      case (state)
        IDLE: begin
          if (ar_hs) begin
            count <= ar.len;
            state <= PREBURST;
          end
        end
        PREBURST: state <= BURST; // SRAM read in flight.
        BURST: begin
          if (capture) begin
            r_valid <= 1'b1;
          end else if (r_hs) begin
            r_valid <= 1'b0;
            if (count == '0) begin
              state <= IDLE;
            end else begin
              count <= count - 8'd1;
              state <= PREBURST;
            end
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  ////////////////////////////////////////
  // Request and beat registers
  ////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (ar_hs) begin
      addr    <= ar.addr;
      len_q   <= ar.len;
      burst_q <= ar.burst;
      r.id    <= ar.id;
    end else if (r_hs) begin
      addr <= ssram_pkg::next_beat_addr(addr, len_q, burst_q);
    end
    if (capture) begin
      r.data <= in_range ? a_rdata : '0;
      r.resp <= in_range ? ssram_pkg::OKAY : ssram_pkg::DECERR;
      r.last <= (count == '0);
    end
  end

endmodule

//--- design/dp_sram.sv
/* Dual-port SRAM */

`timescale 1ns/1ps
`include "ssram_params.svh"

module dp_sram (
  input  logic                           clk,
  input  logic                           a_en,
  input  logic [`SSRAM_DEPTH_LOG2-1:0]   a_addr,
  output logic [`SSRAM_DATA_WIDTH-1:0]   a_rdata,
  input  logic                           b_en,
  input  logic [`SSRAM_STRB_WIDTH-1:0]   b_we,
  input  logic [`SSRAM_DEPTH_LOG2-1:0]   b_addr,
  input  logic [`SSRAM_DATA_WIDTH-1:0]   b_wdata
);

  logic [`SSRAM_DATA_WIDTH-1:0] mem [2**`SSRAM_DEPTH_LOG2];

  ////////////////////////////////////////
  // Port A, registered read
  ////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (a_en) begin
      a_rdata <= mem[a_addr]; // Old word on a same-cycle write.
    end
  end

  ////////////////////////////////////////
  // Port B, byte-enabled write
  ////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (b_en) begin
      for (int i = 0; i < `SSRAM_STRB_WIDTH; i++) begin
        if (b_we[i]) mem[b_addr][8*i +: 8] <= b_wdata[8*i +: 8];
      end
    end
  end

endmodule

//--- design/ssram_pkg.sv
/* SSRAM AXI types */

`include "ssram_params.svh"

package ssram_pkg;

  typedef enum logic [1:0] {
    FIXED = 2'b00,
    INCR  = 2'b01,
    WRAP  = 2'b10,
    RSVD  = 2'b11
  } axi_burst_t;

  typedef enum logic [1:0] {
    OKAY   = 2'b00,
    EXOKAY = 2'b01,
    SLVERR = 2'b10,
    DECERR = 2'b11
  } axi_resp_t;

  ////////////////////////////////////////
  // Channel payloads
  ////////////////////////////////////////
  typedef struct packed {
    logic [`SSRAM_ID_WIDTH-1:0] id;
    logic [31:0]                addr;
    logic [7:0]                 len;
    axi_burst_t                 burst;
  } axi_ax_t; // Shared by AW and AR.

  typedef struct packed {
    logic [`SSRAM_DATA_WIDTH-1:0] data;
    logic [`SSRAM_STRB_WIDTH-1:0] strb;
    logic                         last;
  } axi_w_t;

  typedef struct packed {
    logic [`SSRAM_ID_WIDTH-1:0] id;
    axi_resp_t                  resp;
  } axi_b_t;

  typedef struct packed {
    logic [`SSRAM_ID_WIDTH-1:0]   id;
    logic [`SSRAM_DATA_WIDTH-1:0] data;
    axi_resp_t                    resp;
    logic                         last;
  } axi_r_t;

  // Address of the following beat, full 8-byte beats only.
  function automatic logic [31:0] next_beat_addr(input logic [31:0] addr,
                                                 input logic [7:0]  len,
                                                 input axi_burst_t  burst);
    logic [31:0] mask;
    mask = {21'b0, len, 3'b111}; // Wrap window minus one.
    case (burst)
      FIXED:   next_beat_addr = addr;
      WRAP:    next_beat_addr = (addr & ~mask) | ((addr + 32'd8) & mask);
      default: next_beat_addr = addr + 32'd8; // INCR and RSVD.
    endcase
  endfunction

endpackage

//--- include/ssram_params.svh
/* SSRAM AXI sizing */

`ifndef SSRAM_PARAMS_SVH
`define SSRAM_PARAMS_SVH

////////////////////////////////////////
// AXI channel widths
////////////////////////////////////////
`define SSRAM_ID_WIDTH 4
`define SSRAM_DATA_WIDTH 64
`define SSRAM_STRB_WIDTH 8

////////////////////////////////////////
// Memory size
////////////////////////////////////////
`define SSRAM_DEPTH_LOG2 10 // 1024 words of 8 bytes.

`endif
